// ==== verilog.f ====
hdl/blob_pkg.sv
hdl/line_labeler.sv
hdl/table_write_arbiter.sv
hdl/label_table.sv
hdl/blob_summary.sv
hdl/blob_top.sv
verification/blob_tb.sv

// ==== verification/blob_tb.sv ====
`timescale 1ns/10ps

module blob_tb;

    localparam int MAX_ROWS = 16;
    localparam int TIMEOUT_CYCLES = 5000;
    localparam int LAST_COL = blob_pkg::IMG_COL - 1;

    logic             clk;
    logic             rst_n;
    logic             in_valid;
    logic             in_seq;
    logic             out_valid;
    blob_pkg::label_t out_count;

    logic             img [MAX_ROWS][blob_pkg::IMG_COL];
    int               rows;
    int               seed;
    string            test_name;
    blob_pkg::label_t exp_count;
    logic             awaiting;     // a result may show up now
    int               mismatches;
    int               protocol_errors;
    int               timeouts;

    blob_top DUT (
        .i_clk   (clk),
        .i_rst_n (rst_n),
        .i_valid (in_valid),
        .i_seq   (in_seq),
        .o_valid (out_valid),
        .o_count (out_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    a_pulse: assert property (@(posedge clk) disable iff (!rst_n) out_valid |=> !out_valid)
        else begin
            protocol_errors++;
            $display("o_valid stayed high for more than one cycle in %s", test_name);
        end

    a_window: assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> awaiting)
        else begin
            protocol_errors++;
            $display("o_valid went high while no result was due in %s", test_name);
        end

    a_count: assert property (@(posedge clk) disable iff (!rst_n)
                              out_valid |-> out_count == exp_count)
        else begin
            mismatches++;
            $display("MISMATCH %s expected %0d actual %0d", test_name, exp_count, out_count);
        end

    task automatic clear_image(input int n_rows);
        rows = n_rows;
        for (int r = 0; r < MAX_ROWS; r++) begin
            for (int c = 0; c < blob_pkg::IMG_COL; c++) begin
                img[r][c] = 1'b0;
            end
        end
    endtask

    task automatic draw_rect(input int r0, input int c0, input int h, input int w);
        for (int r = r0; r < r0 + h; r++) begin
            for (int c = c0; c < c0 + w; c++) begin
                img[r][c] = 1'b1;
            end
        end
    endtask

    // two arms on a bottom bar in 5 rows by 13 columns
    task automatic draw_u(input int r0, input int c0);
        draw_rect(r0, c0, 4, 3);
        draw_rect(r0, c0 + 10, 4, 3);
        draw_rect(r0 + 4, c0, 1, 13);
    endtask

    function automatic int pick(input int lo, input int hi);
        int raw;
        raw = $random(seed);
        return lo + int'($unsigned(raw) % (hi - lo + 1));
    endfunction

    function automatic logic is_blob_pixel(input int r, input int c);
        if (r < 1 || r >= rows || c < 1 || c >= LAST_COL) begin
            return 1'b0;    // first row and side columns are background
        end
        return img[r][c];
    endfunction

    // 4-connected flood fill, then the 1/8 of max rule
    function automatic int reference_count();
        bit seen [MAX_ROWS][blob_pkg::IMG_COL];
        int areas[$];
        int stack[$];
        int max_area;
        int area;
        int total;
        int pos;
        int r;
        int c;
        int nr;
        int nc;
        max_area = 0;
        total = 0;
        for (int sr = 0; sr < MAX_ROWS; sr++) begin
            for (int sc = 0; sc < blob_pkg::IMG_COL; sc++) begin
                seen[sr][sc] = 1'b0;
            end
        end
        for (int sr = 1; sr < rows; sr++) begin
            for (int sc = 1; sc < LAST_COL; sc++) begin
                if (is_blob_pixel(sr, sc) && !seen[sr][sc]) begin
                    area = 0;
                    seen[sr][sc] = 1'b1;
                    stack.push_back(sr * blob_pkg::IMG_COL + sc);
                    while (stack.size() > 0) begin
                        pos = stack.pop_back();
                        r = pos / blob_pkg::IMG_COL;
                        c = pos % blob_pkg::IMG_COL;
                        area++;
                        for (int k = 0; k < 4; k++) begin
                            nr = r + ((k == 0) ? -1 : (k == 1) ? 1 : 0);
                            nc = c + ((k == 2) ? -1 : (k == 3) ? 1 : 0);
                            if (is_blob_pixel(nr, nc) && !seen[nr][nc]) begin
                                seen[nr][nc] = 1'b1;
                                stack.push_back(nr * blob_pkg::IMG_COL + nc);
                            end
                        end
                    end
                    areas.push_back(area);
                    if (area > max_area) begin
                        max_area = area;
                    end
                end
            end
        end
        foreach (areas[i]) begin
            if (areas[i] > (max_area >> 3)) begin
                total++;
            end
        end
        return total;
    endfunction

    // rectangles with at least one background pixel between them
    task automatic place_random_rects(input int n_rects);
        int   r0q[$];
        int   c0q[$];
        int   hq[$];
        int   wq[$];
        int   r0;
        int   c0;
        int   h;
        int   w;
        logic clash;
        logic placed;
        clear_image(12);
        for (int n = 0; n < n_rects; n++) begin
            placed = 1'b0;
            for (int attempt = 0; attempt < 40 && !placed; attempt++) begin
                h = pick(1, 3);
                w = pick(1, 30);
                r0 = pick(1, rows - h);
                c0 = pick(1, LAST_COL - w);
                clash = 1'b0;
                foreach (r0q[i]) begin
                    if (r0 - 1 <= r0q[i] + hq[i] - 1 && r0 + h >= r0q[i] &&
                        c0 - 1 <= c0q[i] + wq[i] - 1 && c0 + w >= c0q[i]) begin
                        clash = 1'b1;
                    end
                end
                if (!clash) begin
                    r0q.push_back(r0);
                    c0q.push_back(c0);
                    hq.push_back(h);
                    wq.push_back(w);
                    draw_rect(r0, c0, h, w);
                    placed = 1'b1;
                end
            end
        end
    endtask

    task automatic run_frame(input string name);
        int wait_cycles;
        test_name = name;
        exp_count = blob_pkg::label_t'(reference_count());
        for (int r = 0; r < rows; r++) begin
            for (int c = 0; c < blob_pkg::IMG_COL; c++) begin
                @(posedge clk);
                in_valid <= 1'b1;
                in_seq <= img[r][c];
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;   // frame ends here
        in_seq <= 1'b0;
        awaiting = 1'b1;
        wait_cycles = 0;
        @(negedge clk);
        while (!out_valid && wait_cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (!out_valid) begin
            timeouts++;
            $display("%s: no result before timeout", name);
        end
        @(posedge clk);
        awaiting = 1'b0;
        @(posedge clk);
    endtask

    initial begin
        seed = 90080;
        mismatches = 0;
        protocol_errors = 0;
        timeouts = 0;
        awaiting = 1'b0;
        test_name = "reset";
        exp_count = '0;
        rows = 0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_seq = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        a_reset_count: assert (out_count == '0)
            else begin
                mismatches++;
                $display("MISMATCH reset expected 0 actual %0d", out_count);
            end
        a_reset_valid: assert (out_valid == 1'b0)
            else begin
                protocol_errors++;
                $display("o_valid was high right after reset");
            end
        repeat (4) @(posedge clk);

        clear_image(4);
        run_frame("empty");

        clear_image(8);
        draw_rect(2, 20, 4, 10);
        draw_rect(2, 100, 4, 10);
        draw_rect(3, 300, 4, 10);
        run_frame("three_rects");

        clear_image(8);
        draw_u(1, 10);
        run_frame("u_shape");

        clear_image(8);
        draw_u(1, 10);
        draw_rect(1, 40, 5, 2);
        run_frame("u_and_bar");

        clear_image(10);
        draw_rect(1, 10, 8, 80);
        draw_rect(1, 200, 2, 40);   // exactly 1/8 of the big one
        run_frame("threshold");

        clear_image(6);
        draw_rect(0, 0, 1, blob_pkg::IMG_COL);
        draw_rect(0, 0, 6, 1);
        draw_rect(0, LAST_COL, 6, 1);
        run_frame("edge_lines");

        draw_rect(0, 0, 4, 6);
        draw_rect(2, 630, 3, 10);
        run_frame("edge_clip");

        clear_image(8);
        draw_rect(1, 50, 6, 100);
        draw_rect(1, 300, 6, 100);
        run_frame("b2b_first");

        clear_image(8);
        draw_rect(1, 50, 6, 100);
        draw_rect(1, 300, 2, 30);   // stale area in label 2 would count it
        run_frame("b2b_second");

        for (int i = 0; i < 3; i++) begin
            place_random_rects(6);
            run_frame($sformatf("random_%0d", i));
        end

        $display("errors: mismatch %0d, protocol %0d, timeout %0d",
                 mismatches, protocol_errors, timeouts);
        if (mismatches + protocol_errors + timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== hdl/blob_top.sv ====
`timescale 1ns/10ps

module blob_top (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_valid,
    input  logic              i_seq,
    output logic              o_valid,
    output blob_pkg::label_t  o_count
);

    blob_pkg::tbl_req_t lab_req;
    blob_pkg::tbl_req_t sum_req;
    blob_pkg::tbl_req_t tbl_req;
    logic               sum_grant;
    logic               frame_done;

    blob_pkg::label_t   lab_raddr;
    blob_pkg::label_t   lab_parent;
    blob_pkg::label_t   sum_raddr;
    blob_pkg::label_t   sum_parent;
    blob_pkg::area_t    sum_area;

    line_labeler u_labeler (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_valid      (i_valid),
        .i_seq        (i_seq),
        .i_parent     (lab_parent),
        .o_raddr      (lab_raddr),
        .o_req        (lab_req),
        .o_frame_done (frame_done)
    );

    table_write_arbiter u_arbiter (
        .i_lab_req   (lab_req),
        .i_sum_req   (sum_req),
        .o_req       (tbl_req),
        .o_sum_grant (sum_grant)
    );

    label_table u_table (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_req        (tbl_req),
        .i_lab_raddr  (lab_raddr),
        .i_sum_raddr  (sum_raddr),
        .o_lab_parent (lab_parent),
        .o_sum_parent (sum_parent),
        .o_sum_area   (sum_area)
    );

    blob_summary u_summary (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_frame_done (frame_done),
        .i_grant      (sum_grant),
        .i_parent     (sum_parent),
        .i_area       (sum_area),
        .o_raddr      (sum_raddr),
        .o_req        (sum_req),
        .o_valid      (o_valid),
        .o_count      (o_count)
    );

endmodule

// ==== hdl/blob_summary.sv ====
`timescale 1ns/10ps

module blob_summary (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_frame_done,
    input  logic                i_grant,
    input  blob_pkg::label_t    i_parent,
    input  blob_pkg::area_t     i_area,
    output blob_pkg::label_t    o_raddr,
    output blob_pkg::tbl_req_t  o_req,
    output logic                o_valid,
    output blob_pkg::label_t    o_count
);

    localparam blob_pkg::label_t LAST_LABEL = blob_pkg::label_t'(blob_pkg::NUM_LABELS - 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_MERGE,
        S_MAX,
        S_COUNT,
        S_OUTPUT
    } state_e;

    state_e           state_r;
    blob_pkg::label_t idx_r;
    logic             step_r;   // 0 add area, 1 clear label
    blob_pkg::area_t  max_r;
    blob_pkg::label_t cnt_r;
    blob_pkg::label_t count_r;

    logic             need_merge;
    logic             hit;
    blob_pkg::label_t cnt_nxt;

    assign o_raddr = idx_r;
    assign o_valid = (state_r == S_OUTPUT);
    assign o_count = count_r;

    assign need_merge = (i_parent != '0) && (i_parent != idx_r);
    assign hit = i_area > (max_r >> 3);
    assign cnt_nxt = cnt_r + blob_pkg::label_t'(hit);

    always_comb begin
        o_req = '0;
        if (state_r == S_MERGE && need_merge) begin
            if (!step_r) begin
                o_req.op = blob_pkg::TBL_ADD_AREA;
                o_req.addr = i_parent;
                o_req.amount = i_area;
            end else begin
                o_req.op = blob_pkg::TBL_CLEAR;
                o_req.addr = idx_r;
            end
        end else if (state_r == S_COUNT) begin
            o_req.op = blob_pkg::TBL_CLEAR;   // leaves the table empty
            o_req.addr = idx_r;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r <= S_IDLE;
            idx_r <= '0;
            step_r <= 1'b0;
            max_r <= '0;
            cnt_r <= '0;
            count_r <= '0;
        end else begin
            case (state_r)
                S_IDLE: begin
                    if (i_frame_done) begin
                        state_r <= S_MERGE;
                        idx_r <= LAST_LABEL;
                        step_r <= 1'b0;
                        max_r <= '0;
                        cnt_r <= '0;
                    end
                end
                S_MERGE: begin
                    if (!need_merge || (i_grant && step_r)) begin
                        step_r <= 1'b0;
                        if (idx_r == blob_pkg::label_t'(1)) begin
                            state_r <= S_MAX;
                            idx_r <= '0;
                        end else begin
                            idx_r <= idx_r - 1'b1;
                        end
                    end else if (i_grant) begin
                        step_r <= 1'b1;
                    end
                end
                S_MAX: begin
                    if (i_area > max_r) begin
                        max_r <= i_area;
                    end
                    if (idx_r == LAST_LABEL) begin
                        state_r <= S_COUNT;
                    end
                    idx_r <= idx_r + 1'b1;  // wraps to 0
                end
                S_COUNT: begin
                    if (i_grant) begin
                        cnt_r <= cnt_nxt;
                        idx_r <= idx_r + 1'b1;
                        if (idx_r == LAST_LABEL) begin
                            count_r <= cnt_nxt;
                            state_r <= S_OUTPUT;
                        end
                    end
                end
                S_OUTPUT: state_r <= S_IDLE;
                default: state_r <= S_IDLE;
            endcase
        end
    end

endmodule

// ==== hdl/label_table.sv ====
`timescale 1ns/10ps

module label_table (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  blob_pkg::tbl_req_t  i_req,
    input  blob_pkg::label_t    i_lab_raddr,
    input  blob_pkg::label_t    i_sum_raddr,
    output blob_pkg::label_t    o_lab_parent,
    output blob_pkg::label_t    o_sum_parent,
    output blob_pkg::area_t     o_sum_area
);

    blob_pkg::label_t parent_r [blob_pkg::NUM_LABELS];
    blob_pkg::area_t  area_r [blob_pkg::NUM_LABELS];

    // combinational read ports
    assign o_lab_parent = parent_r[i_lab_raddr];
    assign o_sum_parent = parent_r[i_sum_raddr];
    assign o_sum_area = area_r[i_sum_raddr];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < blob_pkg::NUM_LABELS; i++) begin
                parent_r[i] <= '0;
                area_r[i] <= '0;
            end
        end else begin
            case (i_req.op)
                blob_pkg::TBL_SET_PARENT: begin
                    parent_r[i_req.addr] <= i_req.parent;
                end
                blob_pkg::TBL_ADD_AREA: begin
                    area_r[i_req.addr] <= area_r[i_req.addr] + i_req.amount;
                end
                blob_pkg::TBL_CLEAR: begin
                    parent_r[i_req.addr] <= '0;
                    area_r[i_req.addr] <= '0;
                end
                default: ;  // nop
            endcase
        end
    end

endmodule

// ==== hdl/table_write_arbiter.sv ====
`timescale 1ns/10ps

module table_write_arbiter (
    input  blob_pkg::tbl_req_t  i_lab_req,
    input  blob_pkg::tbl_req_t  i_sum_req,
    output blob_pkg::tbl_req_t  o_req,
    output logic                o_sum_grant
);

    logic lab_busy;

    // labeller never stalls, so it always wins
    assign lab_busy = (i_lab_req.op != blob_pkg::TBL_NOP);

    always_comb begin
        if (lab_busy) begin
            o_req = i_lab_req;
        end else begin
            o_req = i_sum_req;
        end
    end

    // summary only moves on in a cycle where its request reached the table
    assign o_sum_grant = !lab_busy;

endmodule

// ==== hdl/line_labeler.sv ====
`timescale 1ns/10ps

module line_labeler (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_valid,
    input  logic                i_seq,
    input  blob_pkg::label_t    i_parent,
    output blob_pkg::label_t    o_raddr,
    output blob_pkg::tbl_req_t  o_req,
    output logic                o_frame_done
);

    localparam blob_pkg::label_t LAST_LABEL = blob_pkg::label_t'(blob_pkg::NUM_LABELS - 1);
    localparam logic [blob_pkg::COL_W-1:0] LAST_COL =
        blob_pkg::COL_W'(blob_pkg::IMG_COL - 1);

    logic [blob_pkg::COL_W-1:0] col_r;
    logic                       first_row_r;
    logic                       in_frame_r;
    blob_pkg::label_t           left_r;
    blob_pkg::label_t           next_free_r;
    blob_pkg::tbl_req_t         pend_r;     // deferred area increment
    blob_pkg::tbl_req_t         pend_nxt;

    blob_pkg::label_t row_buf [blob_pkg::IMG_COL];  // labels of the previous row

    blob_pkg::label_t up_lbl;
    blob_pkg::label_t big_lbl;
    blob_pkg::label_t small_lbl;
    blob_pkg::label_t cur_lbl;
    logic             fg;
    logic             merge;
    logic             fresh;
    logic             link;
    blob_pkg::label_t link_addr;
    blob_pkg::label_t link_parent;
    blob_pkg::area_t  pend_amt;

    assign up_lbl = row_buf[blob_pkg::IMG_COL-1];
    assign fg = i_valid && i_seq && !first_row_r && (col_r != '0) && (col_r != LAST_COL);
    assign merge = (left_r != '0) && (up_lbl != '0) && (left_r != up_lbl);
    assign big_lbl = (left_r > up_lbl) ? left_r : up_lbl;
    assign small_lbl = (left_r > up_lbl) ? up_lbl : left_r;

    assign o_raddr = big_lbl;   // one-level root lookup
    assign o_frame_done = in_frame_r && !i_valid;
    assign pend_amt = (pend_r.op == blob_pkg::TBL_ADD_AREA) ? pend_r.amount : '0;

    always_comb begin
        cur_lbl = '0;
        fresh = 1'b0;
        link = 1'b0;
        link_addr = '0;
        link_parent = '0;
        if (fg) begin
            if (left_r != '0) begin
                cur_lbl = left_r;
                if (merge && i_parent > small_lbl) begin
                    link = 1'b1;
                    link_addr = i_parent;
                    link_parent = small_lbl;
                end else if (merge && i_parent < small_lbl) begin
                    link = 1'b1;
                    link_addr = small_lbl;
                    link_parent = i_parent;
                end
            end else if (up_lbl != '0) begin
                cur_lbl = up_lbl;
            end else begin
                cur_lbl = next_free_r;
                fresh = 1'b1;
                link = 1'b1;    // new root points to itself
                link_addr = next_free_r;
                link_parent = next_free_r;
            end
        end
    end

    // table slot goes to the link if any, the area otherwise
    always_comb begin
        o_req = '0;
        pend_nxt = '0;
        if (fg && link) begin
            o_req.op = blob_pkg::TBL_SET_PARENT;
            o_req.addr = link_addr;
            o_req.parent = link_parent;
            pend_nxt.op = blob_pkg::TBL_ADD_AREA;
            pend_nxt.addr = cur_lbl;
            pend_nxt.amount = pend_amt + 1'b1;
        end else if (fg) begin
            // a pending amount always belongs to the running label
            o_req.op = blob_pkg::TBL_ADD_AREA;
            o_req.addr = cur_lbl;
            o_req.amount = pend_amt + 1'b1;
        end else if (pend_r.op == blob_pkg::TBL_ADD_AREA) begin
            o_req = pend_r;     // flush on a free cycle
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            row_buf[0] <= cur_lbl;
            for (int i = 1; i < blob_pkg::IMG_COL; i++) begin
                row_buf[i] <= row_buf[i-1];
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            col_r <= '0;
            first_row_r <= 1'b1;
            in_frame_r <= 1'b0;
            left_r <= '0;
            next_free_r <= blob_pkg::label_t'(1);
            pend_r <= '0;
        end else begin
            in_frame_r <= i_valid;
            pend_r <= pend_nxt;
            if (i_valid) begin
                left_r <= cur_lbl;
                if (col_r == LAST_COL) begin
                    col_r <= '0;
                    first_row_r <= 1'b0;
                end else begin
                    col_r <= col_r + 1'b1;
                end
                if (fresh && next_free_r != LAST_LABEL) begin
                    next_free_r <= next_free_r + 1'b1;  // 255 is reused
                end
            end else if (o_frame_done) begin
                col_r <= '0;
                first_row_r <= 1'b1;
                left_r <= '0;
                next_free_r <= blob_pkg::label_t'(1);
            end
        end
    end

endmodule

// ==== hdl/blob_pkg.sv ====
package blob_pkg;

    // frame geometry
    localparam int IMG_COL = 640;
    localparam int COL_W = 10;

    // label table sizing
    localparam int LABEL_W = 8;
    localparam int NUM_LABELS = 256;
    localparam int AREA_W = 15;

    typedef logic [LABEL_W-1:0] label_t;   // 0 is background
    typedef logic [AREA_W-1:0] area_t;

    typedef enum logic [1:0] {
        TBL_NOP        = 2'd0,
        TBL_SET_PARENT = 2'd1,
        TBL_ADD_AREA   = 2'd2,
        TBL_CLEAR      = 2'd3   // zeroes parent and area
    } tbl_op_e;

    // one write request into the label table
    typedef struct packed {
        tbl_op_e op;
        label_t  addr;
        label_t  parent;
        area_t   amount;
    } tbl_req_t;

endpackage
